//--- r5p_mini.f
+incdir+.
riscv_isa_pkg.sv
r5p_decoder.sv
r5p_alu.sv
r5p_regfile.sv
r5p_pc_counter.sv
r5p_ctrl_fsm.sv
r5p_mini.sv
r5p_mini_sva.sv
r5p_mini_tb_clk.sv
r5p_mini_tb.sv

//--- run.sh
#!/bin/sh
# build the r5p_mini testbench with verilator, run it and scan the log

verilator --binary --timing --assert -sv -f r5p_mini.f --top-module r5p_mini_tb \
  -o r5p_mini_sim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/r5p_mini_sim > sim.log 2>&1
sim_status=$?
cat sim.log

[ "$sim_status" -eq 0 ] && ! grep -q "Some tests failed" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- r5p_mini_tb.sv
// testbench top for the r5p_mini core
// loads a table-driven program, runs it to ebreak, then reads every
// destination register back through the debug port
// a second short run ends on an unknown opcode to exercise illegal

`timescale 1ns/1ps
`include "r5p_mini_consts.svh"
`default_nettype none

module r5p_mini_tb
  import riscv_isa_pkg::*;
;

  logic                    clk, rst;
  logic                    start;
  logic                    imem_we;
  logic [`R5P_IMEM_AW-1:0] imem_addr;
  logic [`R5P_XLEN-1:0]    imem_wdata;
  logic                    done, illegal;
  logic [`R5P_XLEN-1:0]    instret;
  logic [4:0]              dbg_addr;
  logic [`R5P_XLEN-1:0]    dbg_data;

  // program table with one row per instruction
  logic [31:0] tbl_instr[$];
  logic [4:0]  tbl_rd[$];
  logic [31:0] tbl_exp[$];
  bit          tbl_exec[$];  // 0 when jumped over
  bit          tbl_ready = 1'b0;
  int          n_checks  = 0;
  int          n_errors  = 0;

  r5p_mini_tb_clk u_clk (.clk, .rst);

  r5p_mini u_dut (
    .clk, .rst, .start, .imem_we, .imem_addr, .imem_wdata,
    .done, .illegal, .instret, .dbg_addr, .dbg_data
  );

  ////////////////////////////////////////////////////////////
  // RV32I instruction encoders
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input opcode_t opc);
    return {imm, rd, opc};
  endfunction

  // jal offset scrambled as imm[20|10:1|11|19:12]
  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  task automatic add_row(input logic [31:0] ins, input logic [4:0] rd,
                         input logic [31:0] exp, input bit exec);
    tbl_instr.push_back(ins);
    tbl_rd.push_back(rd);
    tbl_exp.push_back(exp);
    tbl_exec.push_back(exec);
  endtask

  // expected values worked out by hand with pc at 4 * row
  task automatic build_table();
    add_row(enc_u(20'h80000, 5'd1, LUI),              5'd1,  32'h8000_0000, 1'b1);
    add_row(enc_i(12'hFFF, 5'd0, 3'b000, 5'd2),       5'd2,  32'hFFFF_FFFF, 1'b1);
    add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd3),       5'd3,  32'h0000_0001, 1'b1);
    add_row(enc_i(12'h800, 5'd0, 3'b000, 5'd4),       5'd4,  32'hFFFF_F800, 1'b1);
    add_row(enc_u(20'h12345, 5'd5, LUI),              5'd5,  32'h1234_5000, 1'b1);
    add_row(enc_i(12'h678, 5'd5, 3'b000, 5'd6),       5'd6,  32'h1234_5678, 1'b1);
    add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd7),   5'd7,  32'h0000_0000, 1'b1); // -1 + 1
    add_row(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd8),   5'd8,  32'h0000_0002, 1'b1); // 1 - -1
    add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd9),   5'd9,  32'h0000_0001, 1'b1);
    add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b011, 5'd10),  5'd10, 32'h0000_0000, 1'b1);
    add_row(enc_r(7'h00, 5'd3, 5'd1, 3'b010, 5'd11),  5'd11, 32'h0000_0001, 1'b1); // min < 1
    add_row(enc_r(7'h00, 5'd1, 5'd3, 3'b011, 5'd12),  5'd12, 32'h0000_0001, 1'b1);
    add_row(enc_r(7'h20, 5'd3, 5'd1, 3'b000, 5'd13),  5'd13, 32'h7FFF_FFFF, 1'b1); // wraps
    add_row(enc_r(7'h00, 5'd4, 5'd6, 3'b111, 5'd14),  5'd14, 32'h1234_5000, 1'b1);
    add_row(enc_r(7'h00, 5'd1, 5'd6, 3'b110, 5'd15),  5'd15, 32'h9234_5678, 1'b1);
    add_row(enc_r(7'h00, 5'd2, 5'd6, 3'b100, 5'd16),  5'd16, 32'hEDCB_A987, 1'b1);
    add_row(enc_i(12'h0FF, 5'd6, 3'b111, 5'd17),      5'd17, 32'h0000_0078, 1'b1);
    add_row(enc_i(12'h7F0, 5'd3, 3'b110, 5'd18),      5'd18, 32'h0000_07F1, 1'b1);
    add_row(enc_i(12'hFFF, 5'd6, 3'b100, 5'd19),      5'd19, 32'hEDCB_A987, 1'b1);
    add_row(enc_i(12'h01F, 5'd3, 3'b001, 5'd20),      5'd20, 32'h8000_0000, 1'b1);
    add_row(enc_i(12'h004, 5'd1, 3'b101, 5'd21),      5'd21, 32'h0800_0000, 1'b1);
    add_row(enc_i(12'h404, 5'd1, 3'b101, 5'd22),      5'd22, 32'hF800_0000, 1'b1); // srai
    add_row(enc_r(7'h00, 5'd3, 5'd6, 3'b001, 5'd23),  5'd23, 32'h2468_ACF0, 1'b1);
    add_row(enc_r(7'h00, 5'd8, 5'd2, 3'b101, 5'd24),  5'd24, 32'h3FFF_FFFF, 1'b1);
    add_row(enc_r(7'h20, 5'd8, 5'd4, 3'b101, 5'd25),  5'd25, 32'hFFFF_FE00, 1'b1);
    add_row(enc_i(12'hFFF, 5'd3, 3'b011, 5'd26),      5'd26, 32'h0000_0001, 1'b1); // sltiu
    add_row(enc_u(20'h00001, 5'd27, AUIPC),           5'd27, 32'h0000_1068, 1'b1);
    add_row(enc_j(21'd8, 5'd28),                      5'd28, 32'h0000_0070, 1'b1);
    add_row(enc_i(12'h055, 5'd0, 3'b000, 5'd29),      5'd29, 32'h0000_0000, 1'b0);
    add_row(enc_i(12'h005, 5'd0, 3'b000, 5'd0),       5'd0,  32'h0000_0000, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_val(input logic [31:0] act, input logic [31:0] exp, input string what);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERR %0t ns: %s, got %08h, expected %08h", $time, what, act, exp);
    end
  endtask

  // one word per cycle from 1 ns after an edge
  task automatic write_imem(input int addr, input logic [31:0] data);
    imem_addr  = addr[`R5P_IMEM_AW-1:0];
    imem_wdata = data;
    imem_we    = 1'b1;
    @(posedge clk);
    #1 imem_we = 1'b0;
  endtask

  // cycles counted from the edge that launches start
  task automatic run_until_done(output int cycles);
    start  = 1'b1;
    cycles = 0;
    @(posedge clk);
    #1 start = 1'b0;
    cycles = 1;
    while (!done) begin
      @(posedge clk);
      #1 cycles++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    int cycles;
    int n_exec;
    start      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    dbg_addr   = 5'd0;
    build_table();
    tbl_ready = 1'b1;
    @(negedge rst);
    @(posedge clk);
    #1;
    check_val({31'b0, done}, 32'd0, "done after reset");
    check_val({31'b0, illegal}, 32'd0, "illegal after reset");
    check_val(instret, 32'd0, "instret after reset");

    // run 1 is the whole table then ebreak
    n_exec = 0;
    foreach (tbl_instr[i]) begin
      write_imem(i, tbl_instr[i]);
      if (tbl_exec[i]) n_exec++;
    end
    write_imem(tbl_instr.size(), 32'h0010_0073);  // ebreak
    run_until_done(cycles);
    check_val(cycles, 2 * (n_exec + 1) + 1, "cycles to done");
    check_val({31'b0, illegal}, 32'd0, "illegal after ebreak");
    check_val(instret, n_exec, "instret after ebreak");
    foreach (tbl_rd[i]) begin
      @(posedge clk);
      #1 dbg_addr = tbl_rd[i];
      #1 check_val(dbg_data, tbl_exp[i], $sformatf("row %0d x%0d", i, tbl_rd[i]));
    end
    check_val({31'b0, done}, 32'd1, "done held after ebreak");

    // run 2 is one addi then an unknown opcode
    write_imem(0, enc_i(12'h007, 5'd0, 3'b000, 5'd30));
    write_imem(1, 32'hFFFF_FFFF);
    run_until_done(cycles);
    check_val(cycles, 32'd5, "cycles to illegal halt");
    check_val({31'b0, illegal}, 32'd1, "illegal after bad opcode");
    check_val(instret, 32'd1, "instret after bad opcode");
    @(posedge clk);
    #1 dbg_addr = 5'd30;
    #1 check_val(dbg_data, 32'd7, "x30 before illegal");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // limit scales with the program length at 4 ns per cycle
  initial begin : watchdog
    int limit_ns;
    wait (tbl_ready);
    limit_ns = 4 * (2 * (tbl_instr.size() + 1) + 20) * 4;
    #(limit_ns);
    $display("timeout: core did not finish within %0d ns", limit_ns);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- r5p_mini_tb_clk.sv
// clock and reset source for the r5p_mini testbench
// free-running clock, rst held high for a fixed number of cycles

`timescale 1ns/1ps
`default_nettype none

module r5p_mini_tb_clk #(
  parameter int PERIOD_NS  = 4,  // full clock period
  parameter int RST_CYCLES = 5
)(
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // sync reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- r5p_mini_sva.sv
// protocol assertions for the r5p_mini core
// bound into every r5p_mini instance, watches the FSM enables and debug port

`timescale 1ns/1ps
`include "r5p_mini_consts.svh"
`default_nettype none

module r5p_mini_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 fetch_en,
  input logic                 exec_en,
  input logic                 done,
  input logic [4:0]           dbg_addr,
  input logic [`R5P_XLEN-1:0] dbg_data
);

  // one FSM state at a time
  a_one_phase: assert property (@(posedge clk) disable iff (rst)
    !(fetch_en && exec_en))
    else $error("fetch_en and exec_en high together");

  // first cycle out of reset
  a_done_low: assert property (@(posedge clk) $fell(rst) |-> !done)
    else $error("done high right after reset");

  a_fetch_exec: assert property (@(posedge clk) disable iff (rst)
    fetch_en |=> exec_en)
    else $error("fetch not followed by execute");

  // after execute, next fetch or halt
  a_exec_next: assert property (@(posedge clk) disable iff (rst)
    exec_en |=> (fetch_en || done))
    else $error("execute not followed by fetch or halt");

  a_x0_zero: assert property (@(posedge clk)
    (dbg_addr == 5'd0) |-> (dbg_data == '0))
    else $error("x0 reads non-zero on debug port");

endmodule

bind r5p_mini r5p_mini_sva u_sva (
  .clk(clk), .rst(rst), .fetch_en(fetch_en), .exec_en(exec_en),
  .done(done), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
);

`default_nettype wire

//--- r5p_mini.sv
// top level of the r5p_mini multicycle RV32I core
// imem is loaded through the write port while stopped, then start runs it
// every instruction takes one fetch and one execute cycle

`timescale 1ns/1ps
`include "r5p_mini_consts.svh"
`default_nettype none

module r5p_mini
  import riscv_isa_pkg::*;
#(
  parameter bit CFG_LOM = 1'b0  // passed to the ALU
)(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  // imem load port
  input  logic                   imem_we,
  input  logic [`R5P_IMEM_AW-1:0] imem_addr,
  input  logic [`R5P_XLEN-1:0]   imem_wdata,
  // status
  output logic                   done,
  output logic                   illegal,
  output logic [`R5P_XLEN-1:0]   instret,
  // debug register read
  input  logic [4:0]             dbg_addr,
  output logic [`R5P_XLEN-1:0]   dbg_data
);

  logic [`R5P_XLEN-1:0] imem [0:`R5P_IMEM_DEPTH-1];
  logic [`R5P_XLEN-1:0] instr;  // fetched word

  logic                 fetch_en, exec_en, clear;
  logic [`R5P_XLEN-1:0] pc, link;
  alu_op_t              alu_op;
  alu_in_t              alu_in;
  result_sign_t         alu_sgn;
  wb_sel_t              wb_sel;
  logic [4:0]           rs1_idx, rs2_idx, rd_idx;
  logic [`R5P_XLEN-1:0] imm_i, imm_u, imm_j;
  logic                 jump, halt, dec_illegal;
  logic [`R5P_XLEN-1:0] rs1, rs2, alu_rd, wb_data;
  logic [`R5P_XLEN:0]   sum;

  ////////////////////////////////////////////////////////////
  // imem and fetch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
    if (fetch_en) begin
      instr <= imem[pc[`R5P_IMEM_AW+1:2]];  // word address
    end
  end

  r5p_ctrl_fsm u_fsm (
    .clk, .rst, .start, .halt, .illegal_in(dec_illegal),
    .fetch_en, .exec_en, .clear, .done, .illegal
  );

  r5p_pc_counter u_pc (
    .clk, .rst, .clear, .step(exec_en), .jump, .target(sum[`R5P_XLEN-1:0]),
    .retire(exec_en && !halt), .pc, .link, .instret
  );

  r5p_decoder u_dec (
    .instr, .alu_op, .alu_in, .alu_sgn, .wb_sel, .rs1_idx, .rs2_idx, .rd_idx,
    .imm_i, .imm_u, .imm_j, .jump, .halt, .illegal(dec_illegal)
  );

  // writeback source
  assign wb_data = (wb_sel == WB_LINK) ? link : alu_rd;

  r5p_regfile u_rf (
    .clk, .rst, .rs1_idx, .rs2_idx, .rs1, .rs2,
    .we(exec_en && (wb_sel != WB_NONE)), .rd_idx, .rd_data(wb_data),
    .dbg_addr, .dbg_data
  );

  r5p_alu #(.CFG_LOM(CFG_LOM)) u_alu (
    .clk, .rst, .alu_op, .alu_in, .alu_sgn, .pc, .rs1, .rs2,
    .imm_i, .imm_u, .imm_j, .rd(alu_rd), .sum
  );

endmodule

`default_nettype wire

//--- r5p_ctrl_fsm.sv
// control FSM of the r5p_mini core
// idle -> fetch -> exec -> fetch ... until a halting instruction
// done is the halt state, illegal is latched with the halt

`timescale 1ns/1ps
`default_nettype none

module r5p_ctrl_fsm
  import riscv_isa_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic start,       // one-cycle pulse
  input  logic halt,        // from decode, valid in exec
  input  logic illegal_in,
  output logic fetch_en,
  output logic exec_en,
  output logic clear,       // restart pc/instret
  output logic done,
  output logic illegal
);

  fsm_state_t state;
  fsm_state_t state_nxt;

  // start only honoured while stopped
  assign clear = start && ((state == ST_IDLE) || (state == ST_HALT));

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (start) state_nxt = ST_FETCH;
      ST_FETCH: state_nxt = ST_EXEC;
      ST_EXEC:  state_nxt = halt ? ST_HALT : ST_FETCH;
      ST_HALT:  if (start) state_nxt = ST_FETCH;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // cause of the halt
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      illegal <= 1'b0;
    end else if (exec_en && halt) begin
      illegal <= illegal_in;  // rises with done
    end
  end

  assign fetch_en = (state == ST_FETCH);
  assign exec_en  = (state == ST_EXEC);
  assign done     = (state == ST_HALT);

endmodule

`default_nettype wire

//--- r5p_pc_counter.sv
// program counter and retired-instruction counter
// pc steps by 4 or loads a jump target once per executed instruction
// clear restarts both counters for a new run

`timescale 1ns/1ps
`include "r5p_mini_consts.svh"
`default_nettype none

module r5p_pc_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear,    // new run
  input  logic                 step,     // end of execute
  input  logic                 jump,
  input  logic [`R5P_XLEN-1:0] target,
  input  logic                 retire,
  output logic [`R5P_XLEN-1:0] pc,
  output logic [`R5P_XLEN-1:0] link,     // pc + 4
  output logic [`R5P_XLEN-1:0] instret
);

  // sequential successor, also the jal return address
  assign link = pc + `R5P_XLEN'd4;

  ////////////////////////////////////////////////////////////
  // pc
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      pc <= `R5P_RESET_PC;
    end else if (step) begin
      pc <= jump ? target : link;
    end
  end

  // retired count, halting instr not counted
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      instret <= '0;
    end else if (retire) begin
      instret <= instret + `R5P_XLEN'd1;
    end
  end

endmodule

`default_nettype wire

//--- r5p_regfile.sv
// integer register file, 31 writable registers plus hardwired x0
// two read ports for execute, one write port, one debug read port

`timescale 1ns/1ps
`include "r5p_mini_consts.svh"
`default_nettype none

module r5p_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [4:0]           rs1_idx,
  input  logic [4:0]           rs2_idx,
  output logic [`R5P_XLEN-1:0] rs1,
  output logic [`R5P_XLEN-1:0] rs2,
  input  logic                 we,
  input  logic [4:0]           rd_idx,
  input  logic [`R5P_XLEN-1:0] rd_data,
  input  logic [4:0]           dbg_addr,
  output logic [`R5P_XLEN-1:0] dbg_data
);

  logic [`R5P_XLEN-1:0] regs [1:31];  // no storage for x0

  // read with x0 forced to zero
  function automatic logic [`R5P_XLEN-1:0] rd_port(input logic [4:0] idx);
    return (idx == 5'd0) ? '0 : regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_idx != 5'd0)) begin  // x0 writes dropped
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs1      = rd_port(rs1_idx);
  assign rs2      = rd_port(rs2_idx);
  assign dbg_data = rd_port(dbg_addr);  // combinational debug

endmodule

`default_nettype wire

//--- r5p_alu.sv
// arithmetic, logic and barrel-shift unit of the r5p_mini core
// one shared adder serves add, sub, slt, sltu and address generation
// CFG_LOM adds a separate operand mux for the logic ops

`timescale 1ns/1ps
`include "r5p_mini_consts.svh"
`default_nettype none

module r5p_alu
  import riscv_isa_pkg::*;
#(
  parameter bit CFG_LOM = 1'b0  // dedicated logic operand mux
)(
  // system signals
  input  logic                 clk,
  input  logic                 rst,
  // controls from decode
  input  alu_op_t              alu_op,
  input  alu_in_t              alu_in,
  input  result_sign_t         alu_sgn,
  // data
  input  logic [`R5P_XLEN-1:0] pc,
  input  logic [`R5P_XLEN-1:0] rs1,
  input  logic [`R5P_XLEN-1:0] rs2,
  input  logic [`R5P_XLEN-1:0] imm_i,
  input  logic [`R5P_XLEN-1:0] imm_u,
  input  logic [`R5P_XLEN-1:0] imm_j,
  output logic [`R5P_XLEN-1:0] rd,
  output logic [`R5P_XLEN:0]   sum    // adder output incl. extension bit
);

  localparam int unsigned XLEN = `R5P_XLEN;
  localparam int unsigned XLOG = $clog2(XLEN);

  logic [XLEN:0]   add_op1;  // one bit wider than XLEN
  logic [XLEN:0]   add_op2;
  logic            add_inv;  // subtract
  logic [XLEN-1:0] log_op1;
  logic [XLEN-1:0] log_op2;
  logic [XLOG-1:0] shf_sam;  // shift amount
  logic [XLEN-1:0] shf_sra;
  logic [XLEN-1:0] shf_srl;
  logic [XLEN-1:0] shf_sll;

  // widen by one bit, signed or unsigned
  function automatic logic [XLEN:0] ext(input logic [XLEN-1:0] v, input result_sign_t s);
    return (s == R_S) ? {v[XLEN-1], v} : {1'b0, v};
  endfunction

  ////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_in)
      AI_R1_R2,
      AI_R1_RA: begin
        add_op1 = ext(rs1, alu_sgn);
        add_op2 = ext(rs2, alu_sgn);
      end
      AI_R1_II: begin
        add_op1 = ext(rs1, alu_sgn);
        add_op2 = ext(imm_i, alu_sgn);
      end
      AI_PC_IU: begin
        add_op1 = ext(pc, R_S);
        add_op2 = ext(imm_u, R_S);
      end
      AI_PC_IJ: begin
        add_op1 = ext(pc, R_S);
        add_op2 = ext(imm_j, R_S);
      end
      default: begin
        add_op1 = '0;
        add_op2 = '0;
      end
    endcase
  end

  // compares are subtractions too
  assign add_inv = (alu_op == AO_SUB) || (alu_op == AO_SLT) || (alu_op == AO_SLTU);

  // two's complement: invert and carry in
  assign sum = add_op1 + (add_inv ? ~add_op2 : add_op2) + {{XLEN{1'b0}}, add_inv};

  ////////////////////////////////////////////////////////////
  // logic operands
  ////////////////////////////////////////////////////////////

  if (CFG_LOM) begin : gen_lom
    assign log_op1 = rs1;
    assign log_op2 = (alu_in == AI_R1_II) ? imm_i : rs2;
  end else begin : gen_lom_shared
    // low bits of the adder operands
    assign log_op1 = add_op1[XLEN-1:0];
    assign log_op2 = add_op2[XLEN-1:0];
  end

  // barrel shifter
  assign shf_sam = (alu_in == AI_R1_II) ? imm_i[XLOG-1:0] : rs2[XLOG-1:0];
  assign shf_sra = $signed(rs1) >>> shf_sam;  // sign fill
  assign shf_srl = rs1 >> shf_sam;
  assign shf_sll = rs1 << shf_sam;

  ////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      AO_ADD,
      AO_SUB:  rd = sum[XLEN-1:0];
      AO_SLT,
      AO_SLTU: rd = {{(XLEN-1){1'b0}}, sum[XLEN]};  // borrow/sign of difference
      AO_AND:  rd = log_op1 & log_op2;
      AO_OR:   rd = log_op1 | log_op2;
      AO_XOR:  rd = log_op1 ^ log_op2;
      AO_SRA:  rd = shf_sra;
      AO_SRL:  rd = shf_srl;
      AO_SLL:  rd = shf_sll;
      default: rd = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- r5p_decoder.sv
// instruction decoder for the r5p_mini core
// purely combinational, driven by the registered instruction word
// unknown encodings and ebreak both raise halt, only the former illegal

`timescale 1ns/1ps
`include "r5p_mini_consts.svh"
`default_nettype none

module r5p_decoder
  import riscv_isa_pkg::*;
(
  input  logic [`R5P_XLEN-1:0] instr,
  output alu_op_t              alu_op,
  output alu_in_t              alu_in,
  output result_sign_t         alu_sgn,
  output wb_sel_t              wb_sel,
  output logic [4:0]           rs1_idx,
  output logic [4:0]           rs2_idx,
  output logic [4:0]           rd_idx,
  output logic [`R5P_XLEN-1:0] imm_i,
  output logic [`R5P_XLEN-1:0] imm_u,
  output logic [`R5P_XLEN-1:0] imm_j,
  output logic                 jump,
  output logic                 halt,
  output logic                 illegal
);

  localparam logic [31:0] EBREAK = 32'h0010_0073;

  opcode_t    opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       bad;  // unsupported encoding

  assign opc = opcode_t'(instr[6:0]);
  assign f3  = instr[14:12];
  assign f7  = instr[31:25];

  assign rs2_idx = instr[24:20];
  assign rd_idx  = instr[11:7];

  // immediates, sign extended from bit 31
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  // lui rides the i-immediate path as x0 + imm_u
  assign imm_i = (opc == LUI) ? imm_u : {{20{instr[31]}}, instr[31:20]};

  // funct3 to ALU op, alt picks sub/sra
  function automatic alu_op_t f3_op(input logic [2:0] f, input logic alt);
    case (f)
      3'b000:  f3_op = alt ? AO_SUB : AO_ADD;
      3'b001:  f3_op = AO_SLL;
      3'b010:  f3_op = AO_SLT;
      3'b011:  f3_op = AO_SLTU;
      3'b100:  f3_op = AO_XOR;
      3'b101:  f3_op = alt ? AO_SRA : AO_SRL;
      3'b110:  f3_op = AO_OR;
      default: f3_op = AO_AND;
    endcase
  endfunction

  always_comb begin
    alu_op  = AO_ADD;
    alu_in  = AI_R1_R2;
    alu_sgn = (f3 == 3'b011) ? R_U : R_S;  // only sltu/sltiu compare unsigned
    wb_sel  = WB_NONE;
    rs1_idx = instr[19:15];
    jump    = 1'b0;
    halt    = 1'b0;
    bad     = 1'b0;
    case (opc)
      OP: begin
        alu_op = f3_op(f3, f7[5]);
        alu_in = (f3 == 3'b001 || f3 == 3'b101) ? AI_R1_RA : AI_R1_R2;
        wb_sel = WB_ALU;
        // funct7 is zero, or 0100000 for sub/sra
        bad = (f7 != 7'b0) && !(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
      end
      OP_IMM: begin
        alu_op = f3_op(f3, (f3 == 3'b101) && f7[5]);  // addi has no sub form
        alu_in = AI_R1_II;
        wb_sel = WB_ALU;
        bad = ((f3 == 3'b001) && (f7 != 7'b0)) ||
              ((f3 == 3'b101) && (f7 != 7'b0) && (f7 != 7'b0100000));
      end
      LUI: begin
        alu_in  = AI_R1_II;
        rs1_idx = 5'd0;  // add to x0
        wb_sel  = WB_ALU;
      end
      AUIPC: begin
        alu_in = AI_PC_IU;
        wb_sel = WB_ALU;
      end
      JAL: begin
        alu_in = AI_PC_IJ;  // sum is the target
        wb_sel = WB_LINK;
        jump   = 1'b1;
      end
      SYSTEM: begin
        halt = 1'b1;
        bad  = (instr != EBREAK);  // ecall, csr
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      halt   = 1'b1;
      wb_sel = WB_NONE;
      jump   = 1'b0;
    end
    illegal = bad;
  end

endmodule

`default_nettype wire

//--- riscv_isa_pkg.sv
// RV32I subset types shared by the r5p_mini core
// holds opcode and ALU control encodings plus the FSM state type
// pull in with a wildcard import in the module header

`default_nettype none

package riscv_isa_pkg;

  //////////////////////////////////////////////////////////////
  // instruction encodings
  //////////////////////////////////////////////////////////////

  // major opcode, bits [6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // register-register
    OP_IMM = 7'b0010011,  // register-immediate
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011   // ebreak only
  } opcode_t;

  //////////////////////////////////////////////////////////////
  // ALU control
  //////////////////////////////////////////////////////////////

  // encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0000,
    AO_SUB  = 4'b1000,
    AO_SLL  = 4'b0001,
    AO_SLT  = 4'b0010,
    AO_SLTU = 4'b0011,
    AO_XOR  = 4'b0100,
    AO_SRL  = 4'b0101,
    AO_SRA  = 4'b1101,
    AO_OR   = 4'b0110,
    AO_AND  = 4'b0111
  } alu_op_t;

  // operand selection
  typedef enum logic [2:0] {
    AI_R1_R2 = 3'd0,  // R-type
    AI_R1_II = 3'd1,  // I-type, also lui via x0
    AI_PC_IU = 3'd2,  // auipc
    AI_PC_IJ = 3'd3,  // jal target
    AI_R1_RA = 3'd4   // R-type shift, amount in rs2
  } alu_in_t;

  typedef enum logic {
    R_S = 1'b0,  // signed extension
    R_U = 1'b1   // unsigned extension
  } result_sign_t;

  // writeback source
  typedef enum logic [1:0] {
    WB_NONE = 2'd0,
    WB_ALU  = 2'd1,
    WB_LINK = 2'd2
  } wb_sel_t;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_FETCH = 2'd1,
    ST_EXEC  = 2'd2,
    ST_HALT  = 2'd3
  } fsm_state_t;

endpackage

`default_nettype wire

//--- r5p_mini_consts.svh
// global constants for the r5p_mini core
// include in any file that needs the data width, imem geometry or reset pc
// all values are plain macros, guarded against double inclusion

`default_nettype none

`ifndef R5P_MINI_CONSTS_SVH
`define R5P_MINI_CONSTS_SVH

`define R5P_XLEN      32                   // data and address width
`define R5P_IMEM_AW   6                    // imem word address bits
`define R5P_IMEM_DEPTH (1 << `R5P_IMEM_AW) // imem words
`define R5P_RESET_PC  32'h0000_0000        // first fetch address

`endif

`default_nettype wire
